// ==== Bender.yml ====
package:
  name: noc_mesh

sources:
  - files:
      - source/noc_pkg.sv
      - source/link_output.sv
      - source/switch_arbiter.sv
      - source/route_decode.sv
      - source/noc_router.sv
      - source/noc_mesh.sv
  - target: test
    files:
      - tests/noc_mesh_assert.sv
      - tests/noc_mesh_tb.sv

// ==== source/link_output.sv ====
`timescale 1ns/10ps

module link_output (
        input logic clk,
        input logic rst_n,
        input logic grant_any,
        input noc_pkg::flit_t flit,
        input logic out_rdy,
        output noc_pkg::link_t out_link
);

        logic valid_q;
        noc_pkg::flit_t flit_q;

        // Valid toward the neighbor
        // A grant only comes when this register is free or draining
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        valid_q <= 1'b0;
                end else if (grant_any) begin
                        valid_q <= 1'b1;
                end else if (out_rdy) begin
                        // Taken, nothing new behind it
                        valid_q <= 1'b0;
                end
        end

        // Payload held while the neighbor stalls
        always_ff @(posedge clk) begin
                if (grant_any) begin
                        flit_q <= flit;
                end
        end

        assign out_link = '{valid: valid_q, flit: flit_q};

endmodule

// ==== source/noc_mesh.sv ====
`timescale 1ns/10ps

module noc_mesh #(
        parameter int mesh_x = 3,
        parameter int mesh_y = 3
) (
        input logic clk,
        input logic rst_n,
        input noc_pkg::link_t local_in [mesh_x*mesh_y],
        output logic [mesh_x*mesh_y-1:0] local_rdy,
        output noc_pkg::link_t local_out [mesh_x*mesh_y]
);

        localparam int num_nodes = mesh_x * mesh_y;

        // Per-node router ports, indexed by node then port
        noc_pkg::link_t in_l [num_nodes][noc_pkg::num_ports];
        logic [noc_pkg::num_ports-1:0] in_r [num_nodes];
        noc_pkg::link_t out_l [num_nodes][noc_pkg::num_ports];
        logic [noc_pkg::num_ports-1:0] out_r [num_nodes];

        for (genvar y = 0; y < mesh_y; y++) begin : g_row
                for (genvar x = 0; x < mesh_x; x++) begin : g_col
                        localparam int n = y * mesh_x + x;

                        // Local port toward the node
                        // Local sink always accepts
                        assign in_l[n][noc_pkg::port_local] = local_in[n];
                        assign local_rdy[n] = in_r[n][noc_pkg::port_local];
                        assign local_out[n] = out_l[n][noc_pkg::port_local];
                        assign out_r[n][noc_pkg::port_local] = 1'b1;

                        // North neighbor sits one row up
                        if (y > 0) begin : g_north
                                assign in_l[n][noc_pkg::port_north] =
                                        out_l[n-mesh_x][noc_pkg::port_south];
                                assign out_r[n][noc_pkg::port_north] =
                                        in_r[n-mesh_x][noc_pkg::port_south];
                        end else begin : g_north_edge
                                assign in_l[n][noc_pkg::port_north] = '0;
                                assign out_r[n][noc_pkg::port_north] = 1'b1;
                        end

                        // East neighbor is the next column
                        if (x < mesh_x - 1) begin : g_east
                                assign in_l[n][noc_pkg::port_east] =
                                        out_l[n+1][noc_pkg::port_west];
                                assign out_r[n][noc_pkg::port_east] =
                                        in_r[n+1][noc_pkg::port_west];
                        end else begin : g_east_edge
                                assign in_l[n][noc_pkg::port_east] = '0;
                                assign out_r[n][noc_pkg::port_east] = 1'b1;
                        end

                        // South neighbor sits one row down
                        if (y < mesh_y - 1) begin : g_south
                                assign in_l[n][noc_pkg::port_south] =
                                        out_l[n+mesh_x][noc_pkg::port_north];
                                assign out_r[n][noc_pkg::port_south] =
                                        in_r[n+mesh_x][noc_pkg::port_north];
                        end else begin : g_south_edge
                                assign in_l[n][noc_pkg::port_south] = '0;
                                assign out_r[n][noc_pkg::port_south] = 1'b1;
                        end

                        // West neighbor is the previous column
                        if (x > 0) begin : g_west
                                assign in_l[n][noc_pkg::port_west] =
                                        out_l[n-1][noc_pkg::port_east];
                                assign out_r[n][noc_pkg::port_west] =
                                        in_r[n-1][noc_pkg::port_east];
                        end else begin : g_west_edge
                                assign in_l[n][noc_pkg::port_west] = '0;
                                assign out_r[n][noc_pkg::port_west] = 1'b1;
                        end

                        noc_router #(
                                .mesh_x (mesh_x),
                                .mesh_y (mesh_y),
                                .my_x   (x),
                                .my_y   (y)
                        ) node (
                                .clk      (clk),
                                .rst_n    (rst_n),
                                .in_link  (in_l[n]),
                                .in_rdy   (in_r[n]),
                                .out_link (out_l[n]),
                                .out_rdy  (out_r[n])
                        );
                end
        end

endmodule

// ==== source/noc_pkg.sv ====
package noc_pkg;

        // Mesh coordinate width
        localparam int coord_w = 2;
        // Node number width, y * mesh_x + x
        localparam int node_w = 4;
        // User payload width
        localparam int payload_w = 24;

        typedef logic [coord_w-1:0] coord_t;
        typedef logic [node_w-1:0] node_t;
        typedef logic [payload_w-1:0] payload_t;

        // Ports per router, four neighbors plus local
        localparam int num_ports = 5;

        // Port numbering
        // North is lower y, south is higher y
        localparam int port_north = 0;
        localparam int port_east = 1;
        localparam int port_south = 2;
        localparam int port_west = 3;
        localparam int port_local = 4;

        // One-hot output port select
        typedef logic [num_ports-1:0] port_sel_t;

        // Single-flit packet, 32 bits
        typedef struct packed {
                coord_t dst_x;
                coord_t dst_y;
                node_t src;
                payload_t payload;
        } flit_t;

        // Forward half of a link
        // Ready travels back as a separate level
        typedef struct packed {
                logic valid;
                flit_t flit;
        } link_t;

endpackage

// ==== source/noc_router.sv ====
`timescale 1ns/10ps

module noc_router #(
        parameter int mesh_x = 3,
        parameter int mesh_y = 3,
        parameter int my_x = 0,
        parameter int my_y = 0
) (
        input logic clk,
        input logic rst_n,
        input noc_pkg::link_t in_link [noc_pkg::num_ports],
        output logic [noc_pkg::num_ports-1:0] in_rdy,
        output noc_pkg::link_t out_link [noc_pkg::num_ports],
        input logic [noc_pkg::num_ports-1:0] out_rdy
);

        localparam int np = noc_pkg::num_ports;

        // Ports that have a neighbor
        // Bit order follows the port numbering, local always present
        localparam logic [np-1:0] port_here = {
                1'b1,
                my_x > 0,
                my_y < mesh_y - 1,
                my_x < mesh_x - 1,
                my_y > 0
        };

        // Per input, from the decode stage
        noc_pkg::port_sel_t req [np];
        noc_pkg::flit_t buf_flit [np];
        logic [np-1:0] pop;

        // Per output, arbitration and steering
        logic [np-1:0] req_col [np];
        logic [np-1:0] grant [np];
        logic [np-1:0] grant_any;
        logic [np-1:0] arb_rdy;
        noc_pkg::flit_t sel_flit [np];

        for (genvar i = 0; i < np; i++) begin : g_in
                route_decode #(
                        .my_x (my_x),
                        .my_y (my_y)
                ) decode (
                        .clk     (clk),
                        .rst_n   (rst_n),
                        .in_link (in_link[i]),
                        .in_rdy  (in_rdy[i]),
                        .req     (req[i]),
                        .flit    (buf_flit[i]),
                        .pop     (pop[i])
                );
        end

        // Crossbar
        always_comb begin
                pop = '0;
                for (int o = 0; o < np; o++) begin
                        sel_flit[o] = '0;
                        for (int i = 0; i < np; i++) begin
                                // Request column for output o
                                req_col[o][i] = req[i][o];
                                // AND-OR mux of the granted buffer
                                sel_flit[o] = sel_flit[o] |
                                        (buf_flit[i] & {$bits(noc_pkg::flit_t){grant[o][i]}});
                                // Grant back to the input as a pop
                                pop[i] = pop[i] | grant[o][i];
                        end
                        grant_any[o] = |grant[o];
                        // Output register free, or draining this cycle
                        // Edge ports never take a flit
                        arb_rdy[o] = port_here[o] & (~out_link[o].valid | out_rdy[o]);
                end
        end

        for (genvar o = 0; o < np; o++) begin : g_out
                switch_arbiter arb (
                        .clk     (clk),
                        .rst_n   (rst_n),
                        .req     (req_col[o]),
                        .out_rdy (arb_rdy[o]),
                        .grant   (grant[o])
                );

                link_output result (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .grant_any (grant_any[o]),
                        .flit      (sel_flit[o]),
                        .out_rdy   (out_rdy[o]),
                        .out_link  (out_link[o])
                );
        end

endmodule

// ==== source/route_decode.sv ====
`timescale 1ns/10ps

module route_decode #(
        parameter int my_x = 0,
        parameter int my_y = 0
) (
        input logic clk,
        input logic rst_n,
        input noc_pkg::link_t in_link,
        output logic in_rdy,
        output noc_pkg::port_sel_t req,
        output noc_pkg::flit_t flit,
        input logic pop
);

        localparam noc_pkg::coord_t here_x = noc_pkg::coord_t'(my_x);
        localparam noc_pkg::coord_t here_y = noc_pkg::coord_t'(my_y);

        // One-flit buffer
        logic buf_valid;
        noc_pkg::flit_t buf_flit;
        logic accept;

        // Ready is the registered empty flag
        // It rises on the edge that pops the buffer
        assign in_rdy = ~buf_valid;
        assign accept = in_link.valid & in_rdy;

        // Occupancy
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        buf_valid <= 1'b0;
                end else if (accept) begin
                        buf_valid <= 1'b1;
                end else if (pop) begin
                        buf_valid <= 1'b0;
                end
        end

        // Flit storage
        always_ff @(posedge clk) begin
                if (accept) begin
                        buf_flit <= in_link.flit;
                end
        end

        assign flit = buf_flit;

        // XY routing
        // X is resolved first, then Y
        always_comb begin
                req = '0;
                if (buf_valid) begin
                        if (buf_flit.dst_x > here_x) begin
                                req[noc_pkg::port_east] = 1'b1;
                        end else if (buf_flit.dst_x < here_x) begin
                                req[noc_pkg::port_west] = 1'b1;
                        end else if (buf_flit.dst_y > here_y) begin
                                // Higher y lies south
                                req[noc_pkg::port_south] = 1'b1;
                        end else if (buf_flit.dst_y < here_y) begin
                                req[noc_pkg::port_north] = 1'b1;
                        end else begin
                                // Arrived
                                req[noc_pkg::port_local] = 1'b1;
                        end
                end
        end

endmodule

// ==== source/switch_arbiter.sv ====
`timescale 1ns/10ps

module switch_arbiter (
        input logic clk,
        input logic rst_n,
        input logic [noc_pkg::num_ports-1:0] req,
        input logic out_rdy,
        output logic [noc_pkg::num_ports-1:0] grant
);

        localparam int np = noc_pkg::num_ports;
        localparam int ptr_w = $clog2(np);

        // First input to look at this cycle
        logic [ptr_w-1:0] ptr;
        logic [ptr_w-1:0] winner;
        logic found;

        // Scan from the pointer, wrapping once around
        always_comb begin : pick
                int unsigned idx;

                idx = 0;
                grant = '0;
                winner = ptr;
                found = 1'b0;
                if (out_rdy) begin
                        for (int i = 0; i < np; i++) begin
                                idx = ptr + i;
                                if (idx >= np) begin
                                        idx = idx - np;
                                end
                                if (!found && req[idx]) begin
                                        grant[idx] = 1'b1;
                                        winner = ptr_w'(idx);
                                        found = 1'b1;
                                end
                        end
                end
        end

        // Pointer moves just past the last winner
        // Each requester is served within np grants
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        ptr <= '0;
                end else if (found) begin
                        if (winner == ptr_w'(np - 1)) begin
                                ptr <= '0;
                        end else begin
                                ptr <= winner + 1'b1;
                        end
                end
        end

endmodule

// ==== src.f ====
source/noc_pkg.sv
source/link_output.sv
source/switch_arbiter.sv
source/route_decode.sv
source/noc_router.sv
source/noc_mesh.sv
tests/noc_mesh_assert.sv
tests/noc_mesh_tb.sv

// ==== tests/noc_mesh_assert.sv ====
`timescale 1ns/10ps

module noc_mesh_assert #(
        parameter int my_x = 0,
        parameter int my_y = 0
) (
        input logic clk,
        input logic rst_n,
        input noc_pkg::link_t out_link [noc_pkg::num_ports],
        input logic [noc_pkg::num_ports-1:0] out_rdy,
        input logic [noc_pkg::num_ports-1:0] grant [noc_pkg::num_ports]
);

        // Failed checks in this router
        int fail_count = 0;

        for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_port
                // Stalled link keeps valid and flit
                a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                        out_link[p].valid && !out_rdy[p] |=> out_link[p] == $past(out_link[p]))
                else begin
                        $error("output %0d of router (%0d,%0d) changed while stalled",
                                p, my_x, my_y);
                        fail_count++;
                end

                // At most one input wins an output
                a_grant: assert property (@(posedge clk) disable iff (!rst_n)
                        $onehot0(grant[p]))
                else begin
                        $error("output %0d of router (%0d,%0d) granted several inputs",
                                p, my_x, my_y);
                        fail_count++;
                end

                // Outputs idle right after reset
                a_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_link[p].valid)
                else begin
                        $error("output %0d of router (%0d,%0d) valid after reset",
                                p, my_x, my_y);
                        fail_count++;
                end
        end

        // Local port only delivers flits addressed to this node
        a_local: assert property (@(posedge clk) disable iff (!rst_n)
                out_link[noc_pkg::port_local].valid |->
                        out_link[noc_pkg::port_local].flit.dst_x == noc_pkg::coord_t'(my_x) &&
                        out_link[noc_pkg::port_local].flit.dst_y == noc_pkg::coord_t'(my_y))
        else begin
                $error("router (%0d,%0d) delivered a flit for another node", my_x, my_y);
                fail_count++;
        end

endmodule

bind noc_router noc_mesh_assert #(
        .my_x (my_x),
        .my_y (my_y)
) chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .out_link (out_link),
        .out_rdy  (out_rdy),
        .grant    (grant)
);

// ==== tests/noc_mesh_tb.sv ====
`timescale 1ns/10ps

module noc_mesh_tb;

        localparam int mesh_x = 3;
        localparam int mesh_y = 3;
        localparam int num_nodes = mesh_x * mesh_y;
        // Cycle limits of the wait loops
        localparam int send_limit = 2000;
        localparam int drain_limit = 500;
        localparam int quiet_cycles = 20;

        logic clk;
        logic rst_n;
        noc_pkg::link_t local_in [num_nodes];
        logic [num_nodes-1:0] local_rdy;
        noc_pkg::link_t local_out [num_nodes];

        // Flits still to enter, tagged by source
        noc_pkg::flit_t tx_q [$];
        // Outstanding deliveries, matched on destination and source
        noc_pkg::flit_t exp_q [$];

        int seed;
        int errors;
        int start_errors;
        int start_asserts;
        int tests_run;
        int failed_tests;
        int arrivals;
        logic stall_seen;
        string cur_test;

        // Failed bound checks per router
        int chk_fails [num_nodes];

        noc_mesh #(
                .mesh_x (mesh_x),
                .mesh_y (mesh_y)
        ) dut0 (
                .clk       (clk),
                .rst_n     (rst_n),
                .local_in  (local_in),
                .local_rdy (local_rdy),
                .local_out (local_out)
        );

        for (genvar y = 0; y < mesh_y; y++) begin : g_chk_row
                for (genvar x = 0; x < mesh_x; x++) begin : g_chk_col
                        assign chk_fails[y * mesh_x + x] =
                                dut0.g_row[y].g_col[x].node.chk.fail_count;
                end
        end

        // 100 ns period
        initial clk = 1'b0;
        always #50 clk = ~clk;

        // Node number is y * mesh_x + x
        function automatic noc_pkg::flit_t make_flit(input int src, input int dst,
                        input noc_pkg::payload_t payload);
                noc_pkg::flit_t f;

                f.dst_x = noc_pkg::coord_t'(dst % mesh_x);
                f.dst_y = noc_pkg::coord_t'(dst / mesh_x);
                f.src = noc_pkg::node_t'(src);
                f.payload = payload;
                return f;
        endfunction

        function automatic int next_for_source(input int n);
                for (int i = 0; i < tx_q.size(); i++) begin
                        if (tx_q[i].src == noc_pkg::node_t'(n)) begin
                                return i;
                        end
                end
                return -1;
        endfunction

        function automatic int count_assert_failures();
                int total;

                total = 0;
                for (int n = 0; n < num_nodes; n++) begin
                        total += chk_fails[n];
                end
                return total;
        endfunction

        task automatic queue_flit(input int src, input int dst);
                noc_pkg::flit_t f;

                f = make_flit(src, dst, noc_pkg::payload_t'($random(seed)));
                tx_q.push_back(f);
                exp_q.push_back(f);
        endtask

        task automatic begin_test(input string name);
                cur_test = name;
                start_errors = errors;
                start_asserts = count_assert_failures();
                arrivals = 0;
                stall_seen = 1'b0;
                tests_run++;
        endtask

        task automatic end_test();
                int failures;

                // Bound checks that fired during this test
                failures = count_assert_failures() - start_asserts;
                if (failures != 0) begin
                        $display("%s: %0d protocol checks failed", cur_test, failures);
                        errors += failures;
                end
                if (errors == start_errors) begin
                        $display("test %s: ok", cur_test);
                end else begin
                        failed_tests++;
                        $display("test %s: %0d errors", cur_test, errors - start_errors);
                end
        endtask

        // One delivery seen at a local output
        task automatic check_arrival(input int node, input noc_pkg::flit_t f);
                int idx;

                idx = -1;
                arrivals++;
                assert (f.dst_x == noc_pkg::coord_t'(node % mesh_x) &&
                        f.dst_y == noc_pkg::coord_t'(node / mesh_x)) else begin
                        $display("ERROR %s: destination expected node %0d actual x %0d y %0d",
                                cur_test, node, f.dst_x, f.dst_y);
                        errors++;
                end
                // Oldest outstanding flit of this source and destination
                for (int i = 0; i < exp_q.size(); i++) begin
                        if (idx < 0 && exp_q[i].dst_x == f.dst_x && exp_q[i].dst_y == f.dst_y &&
                            exp_q[i].src == f.src) begin
                                idx = i;
                        end
                end
                assert (idx >= 0) else begin
                        $display("%s: node %0d got a flit from source %0d that was not outstanding",
                                cur_test, node, f.src);
                        errors++;
                end
                if (idx >= 0) begin
                        assert (exp_q[idx].payload == f.payload) else begin
                                $display("ERROR %s: payload from source %0d expected %h actual %h",
                                        cur_test, f.src, exp_q[idx].payload, f.payload);
                                errors++;
                        end
                        exp_q.delete(idx);
                end
        endtask

        always @(posedge clk) begin
                if (rst_n) begin
                        for (int n = 0; n < num_nodes; n++) begin
                                if (local_out[n].valid) begin
                                        check_arrival(n, local_out[n].flit);
                                end
                        end
                end
        end

        // Each source presents its flits in order, next one after a handshake
        task automatic send_all();
                logic [num_nodes-1:0] busy;
                int held [num_nodes];
                int cycles;
                int idx;

                busy = '0;
                held = '{default: 0};
                cycles = 0;
                do begin
                        @(posedge clk);
                        for (int n = 0; n < num_nodes; n++) begin
                                // Ready during the cycle means taken on this edge
                                if (busy[n] && local_rdy[n]) begin
                                        busy[n] = 1'b0;
                                end else if (busy[n]) begin
                                        // One low cycle is just the buffer refilling
                                        held[n]++;
                                        if (held[n] > 1) begin
                                                stall_seen = 1'b1;
                                        end
                                end
                                if (!busy[n]) begin
                                        idx = next_for_source(n);
                                        if (idx >= 0) begin
                                                local_in[n] <= '{valid: 1'b1, flit: tx_q[idx]};
                                                tx_q.delete(idx);
                                                busy[n] = 1'b1;
                                                held[n] = 0;
                                        end else begin
                                                local_in[n] <= '0;
                                        end
                                end
                        end
                        cycles++;
                end while ((busy != '0 || tx_q.size() != 0) && cycles < send_limit);
                assert (busy == '0 && tx_q.size() == 0) else begin
                        $display("%s: sources still held flits after %0d cycles", cur_test, cycles);
                        errors++;
                        tx_q.delete();
                        for (int n = 0; n < num_nodes; n++) begin
                                local_in[n] <= '0;
                        end
                end
        endtask

        task automatic wait_drain(input int expected);
                int cycles;

                cycles = 0;
                while (exp_q.size() != 0 && cycles < drain_limit) begin
                        @(posedge clk);
                        cycles++;
                end
                assert (exp_q.size() == 0) else begin
                        $display("%s: %0d flits never arrived", cur_test, exp_q.size());
                        errors++;
                        exp_q.delete();
                end
                // Window for late duplicates
                for (int i = 0; i < quiet_cycles; i++) begin
                        @(posedge clk);
                end
                assert (arrivals == expected) else begin
                        $display("ERROR %s: arrivals expected %0d actual %0d",
                                cur_test, expected, arrivals);
                        errors++;
                end
        endtask

        initial begin
                seed = 32'h6994_217e;
                errors = 0;
                tests_run = 0;
                failed_tests = 0;
                rst_n = 1'b0;
                for (int n = 0; n < num_nodes; n++) begin
                        local_in[n] = '0;
                end
                repeat (16) @(posedge clk);
                rst_n <= 1'b1;

                begin_test("reset_state");
                @(posedge clk);
                for (int n = 0; n < num_nodes; n++) begin
                        assert (!local_out[n].valid && local_rdy[n]) else begin
                                $display("ERROR %s: node %0d valid/rdy expected 0/1 actual %b/%b",
                                        cur_test, n, local_out[n].valid, local_rdy[n]);
                                errors++;
                        end
                end
                end_test();

                begin_test("corner_0_to_8");
                queue_flit(0, 8);
                send_all();
                wait_drain(1);
                end_test();

                begin_test("self_node_5");
                queue_flit(5, 5);
                send_all();
                wait_drain(1);
                end_test();

                begin_test("all_random");
                for (int n = 0; n < num_nodes; n++) begin
                        queue_flit(n, $unsigned($random(seed)) % num_nodes);
                end
                send_all();
                wait_drain(num_nodes);
                end_test();

                // Eight sources converge on the center node
                begin_test("hotspot_4");
                for (int k = 0; k < 4; k++) begin
                        for (int n = 0; n < num_nodes; n++) begin
                                if (n != 4) begin
                                        queue_flit(n, 4);
                                end
                        end
                end
                send_all();
                assert (stall_seen) else begin
                        $display("%s: no source ever saw local_rdy held low", cur_test);
                        errors++;
                end
                wait_drain(32);
                end_test();

                begin_test("burst_6_to_2");
                for (int k = 0; k < 10; k++) begin
                        queue_flit(6, 2);
                end
                send_all();
                wait_drain(10);
                end_test();

                $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
                if (errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule
